/* common/mini_core_params.svh */
// mini_core sizes and encodings
// Bus width, register count, fetch buffer depth and major opcodes

`ifndef MINI_CORE_PARAMS_SVH
`define MINI_CORE_PARAMS_SVH

// Data and address width
`define MC_XLEN 32

// Architectural registers
`define MC_NUM_REGS 32

// Fetch FIFO entries
`define MC_FIFO_DEPTH 2

// RV32I major opcodes
`define MC_OPC_OP     7'b0110011
`define MC_OPC_OP_IMM 7'b0010011
`define MC_OPC_LUI    7'b0110111
`define MC_OPC_STORE  7'b0100011

`endif

/* common/mini_core_pkg.sv */
// mini_core shared types
// Word, register index and opcode types, ALU and fetch state encodings

`default_nettype none

`include "mini_core_params.svh"

package mini_core_pkg;

  // Data, address and instruction words
  typedef logic [`MC_XLEN-1:0] word_t;

  // Register file index
  typedef logic [$clog2(`MC_NUM_REGS)-1:0] reg_addr_t;

  // Major opcode field, bits 6:0 of an instruction
  typedef logic [6:0] opcode_t;

  // ALU operations of the kept subset
  typedef enum logic [2:0] {
    ALU_ADD    = 3'd0,
    ALU_SUB    = 3'd1,
    ALU_AND    = 3'd2,
    ALU_OR     = 3'd3,
    ALU_XOR    = 3'd4,
    // Operand b straight through for LUI
    ALU_PASS_B = 3'd5
  } alu_op_e;

  // Instruction bus request phases
  typedef enum logic [1:0] {
    FETCH_IDLE = 2'd0,
    FETCH_REQ  = 2'd1,
    FETCH_WAIT = 2'd2
  } fetch_state_e;

endpackage

`default_nettype wire

/* dv/mini_core_checker.sv */
// mini_core protocol checker
// Bus handshake, outstanding fetch and reset state assertions, bound into the core

`timescale 1ns/10ps
`default_nettype none

module mini_core_checker
  import mini_core_pkg::*;
(
  input  logic  clk_i,
  input  logic  rst_ni,
  input  logic  instr_req_o,
  input  word_t instr_addr_o,
  input  logic  instr_gnt_i,
  input  logic  instr_rvalid_i,
  input  logic  data_req_o,
  input  word_t data_addr_o,
  input  word_t data_wdata_o,
  input  logic  data_gnt_i,
  input  logic  illegal_insn_o,
  input  logic  core_sleep_o
);

  int unsigned fail_count = 0;
  logic        outstanding_q;

  // Set between an instruction grant and its rvalid
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      outstanding_q <= 1'b0;
    end else if (instr_req_o && instr_gnt_i) begin
      outstanding_q <= 1'b1;
    end else if (instr_rvalid_i) begin
      outstanding_q <= 1'b0;
    end
  end

  //////////////////////////////////////////////////
  // Instruction bus
  //////////////////////////////////////////////////

  instr_req_stable_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
    instr_req_o && !instr_gnt_i |=> instr_req_o && $stable(instr_addr_o))
  else begin
    $error("instr_req_o dropped or instr_addr_o changed before grant");
    fail_count++;
  end

  one_outstanding_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
    outstanding_q |-> !instr_req_o)
  else begin
    $error("new instruction request while one is outstanding");
    fail_count++;
  end

  //////////////////////////////////////////////////
  // Data bus and reset state
  //////////////////////////////////////////////////

  data_req_stable_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
    data_req_o && !data_gnt_i |=>
      data_req_o && $stable(data_addr_o) && $stable(data_wdata_o))
  else begin
    $error("data_req_o dropped or store address/data changed before grant");
    fail_count++;
  end

  // Core leaves reset quiet and asleep
  reset_state_a: assert property (@(posedge clk_i)
    $rose(rst_ni) |-> core_sleep_o && !instr_req_o && !data_req_o && !illegal_insn_o)
  else begin
    $error("core not idle and asleep after reset");
    fail_count++;
  end

endmodule

bind mini_core mini_core_checker checker_i (
  .clk_i          ( clk_i          ),
  .rst_ni         ( rst_ni         ),
  .instr_req_o    ( instr_req_o    ),
  .instr_addr_o   ( instr_addr_o   ),
  .instr_gnt_i    ( instr_gnt_i    ),
  .instr_rvalid_i ( instr_rvalid_i ),
  .data_req_o     ( data_req_o     ),
  .data_addr_o    ( data_addr_o    ),
  .data_wdata_o   ( data_wdata_o   ),
  .data_gnt_i     ( data_gnt_i     ),
  .illegal_insn_o ( illegal_insn_o ),
  .core_sleep_o   ( core_sleep_o   )
);

`default_nettype wire

/* dv/mini_core_tb.sv */
// mini_core testbench
// Random RV32I program, register reference model, bus memory models and value checks

`timescale 1ns/10ps
`default_nettype none

`include "mini_core_params.svh"

module mini_core_tb
  import mini_core_pkg::*;
();

  localparam int    PROG_LEN   = 48;
  localparam int    CLK_PERIOD = 20;
  localparam word_t BOOT_ADDR  = 32'h0000_1000;
  // addi x0, x0, 0
  localparam word_t NOP_WORD   = 32'h0000_0013;

  logic  clk;
  logic  rst_n;
  logic  fetch_enable;
  word_t boot_addr;
  logic  instr_req;
  word_t instr_addr;
  logic  instr_gnt;
  logic  instr_rvalid;
  word_t instr_rdata;
  logic  data_req;
  word_t data_addr;
  word_t data_wdata;
  logic  data_gnt;
  logic  illegal_insn;
  logic  core_sleep;

  integer seed;
  word_t  prog [PROG_LEN];
  word_t  model_regs [`MC_NUM_REGS];
  word_t  exp_addr_q [$];
  word_t  exp_data_q [$];
  int     exp_illegal_q [$];
  int     exp_illegal_total;
  int     exp_store_total;

  // Memory model state
  int     grant_count;
  int     instr_gnt_wait;
  int     rvalid_left;
  word_t  rvalid_addr;
  int     data_gnt_wait;
  int     stores_done;
  int     illegal_seen;

  mini_core i_mini_core (
    .clk_i          ( clk          ),
    .rst_ni         ( rst_n        ),
    .fetch_enable_i ( fetch_enable ),
    .boot_addr_i    ( boot_addr    ),
    .instr_req_o    ( instr_req    ),
    .instr_addr_o   ( instr_addr   ),
    .instr_gnt_i    ( instr_gnt    ),
    .instr_rvalid_i ( instr_rvalid ),
    .instr_rdata_i  ( instr_rdata  ),
    .data_req_o     ( data_req     ),
    .data_addr_o    ( data_addr    ),
    .data_wdata_o   ( data_wdata   ),
    .data_gnt_i     ( data_gnt     ),
    .illegal_insn_o ( illegal_insn ),
    .core_sleep_o   ( core_sleep   )
  );

  initial begin
    clk = 1'b0;
    forever begin
      #(CLK_PERIOD / 2);
      clk = ~clk;
    end
  end

  task automatic report_error(input string msg);
    $display("ERROR at %0t: %s", $time, msg);
    $display("Test failures found");
    $fatal(1);
  endtask

  task automatic report_timeout(input string what);
    $display("Timed out at %0t while waiting for %s", $time, what);
    $display("Test failures found");
    $fatal(1);
  endtask

  function automatic int pick_random(input int n);
    return int'($unsigned($random(seed)) % n);
  endfunction

  //////////////////////////////////////////////////
  // Program and reference model
  //////////////////////////////////////////////////

  // Ops 0 to 4 are ADD, SUB, AND, OR and XOR
  function automatic logic [2:0] op_funct3(input int op);
    case (op)
      2:       return 3'b111;
      3:       return 3'b110;
      4:       return 3'b100;
      default: return 3'b000;
    endcase
  endfunction

  function automatic word_t op_result(input int op, input word_t a, input word_t b);
    case (op)
      1:       return a - b;
      2:       return a & b;
      3:       return a | b;
      4:       return a ^ b;
      default: return a + b;
    endcase
  endfunction

  task automatic build_program();
    int          kind;
    int          op;
    reg_addr_t   rd;
    reg_addr_t   rs1;
    reg_addr_t   rs2;
    logic [11:0] imm12;
    logic [19:0] imm20;
    word_t       imm_x;
    word_t       a;
    word_t       b;
    word_t       res;
    logic        writes;
    for (int r = 0; r < `MC_NUM_REGS; r++) begin
      model_regs[r] = '0;
    end
    exp_illegal_total = 0;
    for (int i = 0; i < PROG_LEN; i++) begin
      kind   = pick_random(11);
      // Few registers so results feed later instructions
      rd     = reg_addr_t'(pick_random(8));
      rs1    = reg_addr_t'(pick_random(8));
      rs2    = reg_addr_t'(pick_random(8));
      imm12  = 12'($random(seed));
      imm20  = 20'($random(seed));
      imm_x  = {{20{imm12[11]}}, imm12};
      a      = model_regs[rs1];
      b      = model_regs[rs2];
      res    = '0;
      writes = 1'b1;
      if (i % 4 == 3 || i == PROG_LEN - 1) begin
        kind = 11;
      end else if (i == 5) begin
        kind = 10;
      end
      if (kind < 5) begin
        prog[i] = {(kind == 1) ? 7'b0100000 : 7'b0000000, rs2, rs1, op_funct3(kind), rd,
                   `MC_OPC_OP};
        res     = op_result(kind, a, b);
      end else if (kind < 9) begin
        op      = (kind == 5) ? 0 : kind - 4;
        prog[i] = {imm12, rs1, op_funct3(op), rd, `MC_OPC_OP_IMM};
        res     = op_result(op, a, imm_x);
      end else if (kind == 9) begin
        prog[i] = {imm20, rd, `MC_OPC_LUI};
        res     = {imm20, 12'b0};
      end else if (kind == 10) begin
        // Branch and SLL lie outside the subset
        if (pick_random(2) == 0) begin
          prog[i] = {imm20, rd, 7'b1100011};
        end else begin
          prog[i] = {7'b0000000, rs2, rs1, 3'b001, rd, `MC_OPC_OP};
        end
        exp_illegal_total++;
        writes = 1'b0;
      end else begin
        prog[i] = {imm12[11:5], rs2, rs1, 3'b010, imm12[4:0], `MC_OPC_STORE};
        exp_addr_q.push_back(a + imm_x);
        exp_data_q.push_back(b);
        exp_illegal_q.push_back(exp_illegal_total);
        writes = 1'b0;
      end
      if (writes && rd != '0) begin
        model_regs[rd] = res;
      end
    end
  endtask

  function automatic word_t fetch_word(input word_t addr);
    word_t idx;
    idx = (addr - boot_addr) >> 2;
    if (idx < word_t'(PROG_LEN)) begin
      return prog[idx];
    end
    return NOP_WORD;
  endfunction

  //////////////////////////////////////////////////
  // Memory models
  //////////////////////////////////////////////////

  // Grant after 0 to 3 waiting cycles and rvalid 1 to 2 cycles after the grant
  task automatic step_instr_memory();
    instr_rvalid <= 1'b0;
    if (instr_req && instr_gnt) begin
      assert (instr_addr == boot_addr + word_t'(4 * grant_count))
      else report_error($sformatf("instr_addr_o %h, expected %h", instr_addr,
                                  boot_addr + word_t'(4 * grant_count)));
      grant_count++;
      rvalid_addr    = instr_addr;
      rvalid_left    = 1 + pick_random(2);
      instr_gnt_wait = pick_random(4);
      instr_gnt     <= (instr_gnt_wait == 0);
    end else if (instr_req) begin
      if (instr_gnt_wait > 0) begin
        instr_gnt_wait--;
      end
      instr_gnt <= (instr_gnt_wait == 0);
    end
    if (rvalid_left > 0) begin
      rvalid_left--;
      if (rvalid_left == 0) begin
        instr_rvalid <= 1'b1;
        instr_rdata  <= fetch_word(rvalid_addr);
      end
    end
  endtask

  // Grant after 0 to 4 waiting cycles with stores compared in program order
  task automatic step_data_memory();
    word_t exp_addr;
    word_t exp_data;
    int    exp_illegal;
    if (illegal_insn) begin
      illegal_seen <= illegal_seen + 1;
    end
    if (data_req && data_gnt) begin
      assert (exp_addr_q.size() > 0)
      else report_error("store granted after the last store of the program");
      exp_addr    = exp_addr_q.pop_front();
      exp_data    = exp_data_q.pop_front();
      exp_illegal = exp_illegal_q.pop_front();
      assert (data_addr == exp_addr)
      else report_error($sformatf("data_addr_o %h, expected %h", data_addr, exp_addr));
      assert (data_wdata == exp_data)
      else report_error($sformatf("data_wdata_o %h, expected %h", data_wdata, exp_data));
      assert (illegal_seen == exp_illegal)
      else report_error($sformatf("%0d illegal pulses before store, expected %0d",
                                  illegal_seen, exp_illegal));
      stores_done  <= stores_done + 1;
      data_gnt_wait = pick_random(5);
      data_gnt     <= (data_gnt_wait == 0);
    end else if (data_req) begin
      if (data_gnt_wait > 0) begin
        data_gnt_wait--;
      end
      data_gnt <= (data_gnt_wait == 0);
    end
  endtask

  always @(posedge clk) begin
    if (!rst_n) begin
      instr_gnt    <= 1'b0;
      instr_rvalid <= 1'b0;
      data_gnt     <= 1'b0;
    end else begin
      step_instr_memory();
      step_data_memory();
      assert (i_mini_core.checker_i.fail_count == 0)
      else report_error("bus protocol assertion failed in the checker");
    end
  end

  //////////////////////////////////////////////////
  // Test sequence
  //////////////////////////////////////////////////

  task automatic wait_for_sleep(input logic level, input int limit);
    int cycles;
    cycles = 0;
    while (core_sleep !== level) begin
      @(posedge clk);
      cycles++;
      if (cycles > limit) begin
        report_timeout($sformatf("core_sleep_o to become %0b", level));
      end
    end
  endtask

  task automatic wait_for_stores(input int count, input int limit);
    int cycles;
    cycles = 0;
    while (stores_done < count) begin
      @(posedge clk);
      cycles++;
      if (cycles > limit) begin
        report_timeout($sformatf("store %0d of %0d", stores_done + 1, count));
      end
    end
  endtask

  initial begin
    seed           = 32'he6253639;
    rst_n          = 1'b0;
    fetch_enable   = 1'b0;
    boot_addr      = BOOT_ADDR;
    instr_gnt      = 1'b0;
    instr_rvalid   = 1'b0;
    instr_rdata    = '0;
    data_gnt       = 1'b0;
    grant_count    = 0;
    instr_gnt_wait = 0;
    rvalid_left    = 0;
    rvalid_addr    = '0;
    data_gnt_wait  = 0;
    stores_done    = 0;
    illegal_seen   = 0;
    build_program();
    exp_store_total = exp_data_q.size();
    repeat (8) @(posedge clk);
    rst_n <= 1'b1;
    repeat (4) @(posedge clk);
    assert (core_sleep == 1'b1)
    else report_error("core_sleep_o low after reset with fetch disabled");
    fetch_enable <= 1'b1;
    wait_for_sleep(1'b0, 10);
    wait_for_stores(exp_store_total, PROG_LEN * 40);
    fetch_enable <= 1'b0;
    // Outstanding fetch and trailing no-ops drain
    wait_for_sleep(1'b1, 40);
    assert (illegal_seen == exp_illegal_total)
    else report_error($sformatf("%0d illegal pulses, expected %0d", illegal_seen,
                                exp_illegal_total));
    if (i_mini_core.checker_i.fail_count == 0) begin
      $display("All tests passed!");
      $finish;
    end else begin
      $display("Test failures found");
      $fatal(1);
    end
  end

endmodule

`default_nettype wire

/* flist.f */
+incdir+common
common/mini_core_pkg.sv
hw/fetch/mini_fetch_unit.sv
hw/fetch/mini_fetch_fifo.sv
hw/exec/mini_register_file.sv
hw/exec/mini_exec_unit.sv
hw/mini_core.sv
dv/mini_core_checker.sv
dv/mini_core_tb.sv

/* hw/exec/mini_exec_unit.sv */
// Decode and execute unit
// Runs the RV32I ALU subset and SW at the FIFO head, flags everything else

`timescale 1ns/10ps
`default_nettype none

`include "mini_core_params.svh"

module mini_exec_unit
  import mini_core_pkg::*;
(
  input  logic  clk_i,
  input  logic  rst_ni,

  // Fetch FIFO head
  input  logic  instr_valid_i,
  input  word_t instr_i,
  output logic  pop_o,

  // Data bus, stores only
  output logic  data_req_o,
  output word_t data_addr_o,
  output word_t data_wdata_o,
  input  logic  data_gnt_i,

  output logic  illegal_insn_o,
  output logic  busy_o
);

  opcode_t   opcode;
  logic [2:0] funct3;
  logic [6:0] funct7;
  reg_addr_t rd;
  reg_addr_t rs1;
  reg_addr_t rs2;

  word_t     imm_i;
  word_t     imm_s;
  word_t     imm_u;

  word_t     rf_rdata_a;
  word_t     rf_rdata_b;
  logic      rf_we;

  alu_op_e   f3_op;
  logic      f3_valid;
  alu_op_e   alu_op;
  word_t     operand_b;
  word_t     alu_result;
  logic      is_store;
  logic      illegal;

  //////////////////////////////////////////////////
  // Decode
  //////////////////////////////////////////////////

  assign opcode = instr_i[6:0];
  assign rd     = instr_i[11:7];
  assign funct3 = instr_i[14:12];
  assign rs1    = instr_i[19:15];
  assign rs2    = instr_i[24:20];
  assign funct7 = instr_i[31:25];

  // Sign-extended immediates
  assign imm_i = {{20{instr_i[31]}}, instr_i[31:20]};
  assign imm_s = {{20{instr_i[31]}}, instr_i[31:25], instr_i[11:7]};
  assign imm_u = {instr_i[31:12], 12'b0};

  // funct3 map shared by register and immediate forms
  always_comb begin
    f3_valid = 1'b1;
    case (funct3)
      3'b000:  f3_op = ALU_ADD;
      3'b100:  f3_op = ALU_XOR;
      3'b110:  f3_op = ALU_OR;
      3'b111:  f3_op = ALU_AND;
      default: begin
        f3_op    = ALU_ADD;
        f3_valid = 1'b0;
      end
    endcase
  end

  always_comb begin
    alu_op    = ALU_ADD;
    operand_b = imm_i;
    is_store  = 1'b0;
    illegal   = 1'b0;
    case (opcode)
      `MC_OPC_OP: begin
        operand_b = rf_rdata_b;
        if (funct7 == 7'b0000000) begin
          alu_op  = f3_op;
          illegal = !f3_valid;
        end else if (funct7 == 7'b0100000 && funct3 == 3'b000) begin
          alu_op = ALU_SUB;
        end else begin
          illegal = 1'b1;
        end
      end
      `MC_OPC_OP_IMM: begin
        alu_op  = f3_op;
        illegal = !f3_valid;
      end
      `MC_OPC_LUI: begin
        alu_op    = ALU_PASS_B;
        operand_b = imm_u;
      end
      // Address is formed by the ALU adder
      `MC_OPC_STORE: begin
        operand_b = imm_s;
        is_store  = (funct3 == 3'b010);
        illegal   = (funct3 != 3'b010);
      end
      default: illegal = 1'b1;
    endcase
  end

  //////////////////////////////////////////////////
  // ALU
  //////////////////////////////////////////////////

  always_comb begin
    case (alu_op)
      ALU_SUB:    alu_result = rf_rdata_a - operand_b;
      ALU_AND:    alu_result = rf_rdata_a & operand_b;
      ALU_OR:     alu_result = rf_rdata_a | operand_b;
      ALU_XOR:    alu_result = rf_rdata_a ^ operand_b;
      ALU_PASS_B: alu_result = operand_b;
      default:    alu_result = rf_rdata_a + operand_b;
    endcase
  end

  // ALU ops retire in one cycle and stores wait for the grant
  assign rf_we = instr_valid_i & ~illegal & ~is_store;
  assign pop_o = instr_valid_i & (is_store ? data_gnt_i : 1'b1);

  assign data_req_o   = instr_valid_i & is_store;
  assign data_addr_o  = alu_result;
  assign data_wdata_o = rf_rdata_b;

  assign illegal_insn_o = instr_valid_i & illegal;
  assign busy_o         = data_req_o;

  mini_register_file register_file_i (
    .clk_i     ( clk_i      ),
    .rst_ni    ( rst_ni     ),
    .raddr_a_i ( rs1        ),
    .rdata_a_o ( rf_rdata_a ),
    .raddr_b_i ( rs2        ),
    .rdata_b_o ( rf_rdata_b ),
    .waddr_i   ( rd         ),
    .wdata_i   ( alu_result ),
    .we_i      ( rf_we      )
  );

endmodule

`default_nettype wire

/* hw/exec/mini_register_file.sv */
// Integer register file
// Two combinational read ports, one write port, x0 held at zero

`timescale 1ns/10ps
`default_nettype none

`include "mini_core_params.svh"

module mini_register_file
  import mini_core_pkg::*;
(
  input  logic      clk_i,
  input  logic      rst_ni,

  input  reg_addr_t raddr_a_i,
  output word_t     rdata_a_o,
  input  reg_addr_t raddr_b_i,
  output word_t     rdata_b_o,

  input  reg_addr_t waddr_i,
  input  word_t     wdata_i,
  input  logic      we_i
);

  word_t regs_q [`MC_NUM_REGS];

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      for (int i = 0; i < `MC_NUM_REGS; i++) begin
        regs_q[i] <= '0;
      end
    end else if (we_i && waddr_i != '0) begin
      // x0 keeps its reset value
      regs_q[waddr_i] <= wdata_i;
    end
  end

  assign rdata_a_o = regs_q[raddr_a_i];
  assign rdata_b_o = regs_q[raddr_b_i];

endmodule

`default_nettype wire

/* hw/fetch/mini_fetch_fifo.sv */
// Fetch FIFO
// Small circular buffer between the instruction bus and the exec unit

`timescale 1ns/10ps
`default_nettype none

`include "mini_core_params.svh"

module mini_fetch_fifo
  import mini_core_pkg::*;
(
  input  logic       clk_i,
  input  logic       rst_ni,

  input  logic       push_i,
  input  word_t      push_data_i,

  input  logic       pop_i,
  output logic       valid_o,
  output word_t      head_o,

  output logic [1:0] count_o
);

  localparam int unsigned PTR_W = $clog2(`MC_FIFO_DEPTH);
  localparam logic [PTR_W-1:0] LAST_PTR = PTR_W'(`MC_FIFO_DEPTH - 1);

  word_t            mem_q [`MC_FIFO_DEPTH];
  logic [PTR_W-1:0] wptr_q;
  logic [PTR_W-1:0] rptr_q;
  logic [1:0]       count_q;
  logic             do_push;
  logic             do_pop;

  assign do_push = push_i && (count_q != 2'(`MC_FIFO_DEPTH));
  assign do_pop  = pop_i && valid_o;

  // Entry storage
  always_ff @(posedge clk_i) begin
    if (do_push) begin
      mem_q[wptr_q] <= push_data_i;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wptr_q  <= '0;
      rptr_q  <= '0;
      count_q <= '0;
    end else begin
      if (do_push) begin
        wptr_q <= (wptr_q == LAST_PTR) ? '0 : wptr_q + 1'b1;
      end
      if (do_pop) begin
        rptr_q <= (rptr_q == LAST_PTR) ? '0 : rptr_q + 1'b1;
      end
      // Simultaneous push and pop leave the count alone
      if (do_push && !do_pop) begin
        count_q <= count_q + 2'd1;
      end else if (do_pop && !do_push) begin
        count_q <= count_q - 2'd1;
      end
    end
  end

  assign valid_o = (count_q != 2'd0);
  assign head_o  = mem_q[rptr_q];
  assign count_o = count_q;

endmodule

`default_nettype wire

/* hw/fetch/mini_fetch_unit.sv */
// Instruction fetch unit
// Keeps the PC and runs the request/grant/rvalid phases of the instruction bus

`timescale 1ns/10ps
`default_nettype none

`include "mini_core_params.svh"

module mini_fetch_unit
  import mini_core_pkg::*;
(
  input  logic         clk_i,
  input  logic         rst_ni,

  input  logic         fetch_enable_i,
  input  word_t        boot_addr_i,

  // Instruction bus
  output logic         instr_req_o,
  output word_t        instr_addr_o,
  input  logic         instr_gnt_i,
  input  logic         instr_rvalid_i,
  input  word_t        instr_rdata_i,

  // Fetch FIFO
  input  logic [1:0]   fifo_count_i,
  output logic         push_o,
  output word_t        push_data_o,

  output logic         busy_o
);

  localparam logic [1:0] FIFO_DEPTH = 2'(`MC_FIFO_DEPTH);

  fetch_state_e state_q, state_d;
  word_t        pc_q;
  logic         pc_loaded_q;
  logic         fifo_room;

  // Only ask when the answer is sure to find a free entry
  assign fifo_room = (fifo_count_i < FIFO_DEPTH);

  always_comb begin
    state_d = state_q;
    case (state_q)
      FETCH_IDLE: begin
        if (fetch_enable_i && fifo_room) begin
          state_d = FETCH_REQ;
        end
      end
      // Request is held until granted, even if enable drops
      FETCH_REQ: begin
        if (instr_gnt_i) begin
          state_d = FETCH_WAIT;
        end
      end
      FETCH_WAIT: begin
        if (instr_rvalid_i) begin
          state_d = FETCH_IDLE;
        end
      end
      default: state_d = FETCH_IDLE;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q     <= FETCH_IDLE;
      pc_q        <= '0;
      pc_loaded_q <= 1'b0;
    end else begin
      state_q <= state_d;
      if (state_q == FETCH_IDLE && fetch_enable_i && !pc_loaded_q) begin
        // Boot address taken on the first enabled cycle
        pc_q        <= boot_addr_i;
        pc_loaded_q <= 1'b1;
      end else if (instr_req_o && instr_gnt_i) begin
        pc_q <= pc_q + word_t'(4);
      end
    end
  end

  assign instr_req_o  = (state_q == FETCH_REQ);
  assign instr_addr_o = pc_q;

  assign push_o      = (state_q == FETCH_WAIT) & instr_rvalid_i;
  assign push_data_o = instr_rdata_i;

  // Busy from request until its response
  assign busy_o = (state_q != FETCH_IDLE);

endmodule

`default_nettype wire

/* hw/mini_core.sv */
// mini_core top level
// Fetch unit, fetch FIFO and exec unit, plus the busy/sleep register

`timescale 1ns/10ps
`default_nettype none

module mini_core
  import mini_core_pkg::*;
(
  input  logic  clk_i,
  input  logic  rst_ni,

  input  logic  fetch_enable_i,
  input  word_t boot_addr_i,

  // Instruction bus
  output logic  instr_req_o,
  output word_t instr_addr_o,
  input  logic  instr_gnt_i,
  input  logic  instr_rvalid_i,
  input  word_t instr_rdata_i,

  // Data bus
  output logic  data_req_o,
  output word_t data_addr_o,
  output word_t data_wdata_o,
  input  logic  data_gnt_i,

  output logic  illegal_insn_o,
  output logic  core_sleep_o
);

  logic       fetch_busy;
  logic       exec_busy;
  logic       fifo_push;
  word_t      fifo_push_data;
  logic       fifo_pop;
  logic       fifo_valid;
  word_t      fifo_head;
  logic [1:0] fifo_count;
  logic       core_busy_d;
  logic       core_busy_q;

  mini_fetch_unit fetch_unit_i (
    .clk_i          ( clk_i          ),
    .rst_ni         ( rst_ni         ),
    .fetch_enable_i ( fetch_enable_i ),
    .boot_addr_i    ( boot_addr_i    ),
    .instr_req_o    ( instr_req_o    ),
    .instr_addr_o   ( instr_addr_o   ),
    .instr_gnt_i    ( instr_gnt_i    ),
    .instr_rvalid_i ( instr_rvalid_i ),
    .instr_rdata_i  ( instr_rdata_i  ),
    .fifo_count_i   ( fifo_count     ),
    .push_o         ( fifo_push      ),
    .push_data_o    ( fifo_push_data ),
    .busy_o         ( fetch_busy     )
  );

  mini_fetch_fifo fetch_fifo_i (
    .clk_i       ( clk_i          ),
    .rst_ni      ( rst_ni         ),
    .push_i      ( fifo_push      ),
    .push_data_i ( fifo_push_data ),
    .pop_i       ( fifo_pop       ),
    .valid_o     ( fifo_valid     ),
    .head_o      ( fifo_head      ),
    .count_o     ( fifo_count     )
  );

  mini_exec_unit exec_unit_i (
    .clk_i          ( clk_i          ),
    .rst_ni         ( rst_ni         ),
    .instr_valid_i  ( fifo_valid     ),
    .instr_i        ( fifo_head      ),
    .pop_o          ( fifo_pop       ),
    .data_req_o     ( data_req_o     ),
    .data_addr_o    ( data_addr_o    ),
    .data_wdata_o   ( data_wdata_o   ),
    .data_gnt_i     ( data_gnt_i     ),
    .illegal_insn_o ( illegal_insn_o ),
    .busy_o         ( exec_busy      )
  );

  //////////////////////////////////////////////////
  // Sleep indication
  //////////////////////////////////////////////////

  // Idle only once fetch, buffer and store path are all quiet
  assign core_busy_d = fetch_busy | fifo_valid | exec_busy;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      core_busy_q <= 1'b0;
    end else begin
      core_busy_q <= core_busy_d;
    end
  end

  assign core_sleep_o = ~core_busy_q;

endmodule

`default_nettype wire

/* run_sim.sh */
#!/bin/sh
# Build and run the mini_core testbench with Verilator

verilator --binary --timing --assert -Wno-fatal -f flist.f \
  --top-module mini_core_tb -o mini_core_sim || exit 1
./obj_dir/mini_core_sim > sim.log 2>&1
cat sim.log
grep -q 'All tests passed!' sim.log && echo "Simulation PASSED" || { echo "Simulation FAILED"; exit 1; }
